/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_tile_move
RTL_TOP   ?= tile_move_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb.f */
verilog/tile_move_pkg.sv
verilog/hci_core_mux_static.sv
verilog/tile_move_ctrl.sv
verilog/tile_word_counter.sv
verilog/tile_access_channels.sv
verilog/tile_buffer.sv
verilog/tile_move_top.sv
verif/tile_move_asserts.sv
verif/tb_tile_move.sv

/* verif/tb_tile_move.sv */
// ##########################################################################
// tile mover testbench.
// replays golden jobs against a word memory model with random grant stalls
// and checks addresses, write data, final memory and the job handshake.
// ##########################################################################

`timescale 1ns/1ps

module tb_tile_move;

  localparam int unsigned GOLD_MAX  = 128;          // golden words held.
  localparam int unsigned MEM_WORDS = 256;          // model depth, addr[7:0].

  logic                           clk_i          = 1'b0;
  logic                           rst_n_i        = 1'b0;
  logic                           job_req_i;
  tile_move_pkg::addr_t           src_addr_i, dst_addr_i;
  tile_move_pkg::len_t            len_i;
  logic                           job_ack_o;
  logic                           tcdm_req_o, tcdm_wen_o;
  logic                           tcdm_gnt_i     = 1'b0;
  logic                           tcdm_r_valid_i = 1'b0;
  tile_move_pkg::data_t           tcdm_r_data_i  = '0;
  tile_move_pkg::addr_t           tcdm_add_o;
  tile_move_pkg::data_t           tcdm_data_o;
  logic [tile_move_pkg::BE_W-1:0] tcdm_be_o;

  logic [31:0]          gold [GOLD_MAX];            // raw golden words.
  tile_move_pkg::data_t mem  [MEM_WORDS];
  int unsigned          errors       = 0;
  int unsigned          limit_cycles = 0;
  logic                 limit_ready  = 1'b0;
  logic                 in_job       = 1'b0;        // traffic allowed.
  tile_move_pkg::addr_t cur_src, cur_dst;
  tile_move_pkg::len_t  cur_len;
  int unsigned          cur_base, rd_cnt, wr_cnt;   // src words start at cur_base.

  task automatic check_word(input string name, input tile_move_pkg::data_t exp,
                            input tile_move_pkg::data_t act);
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input tile_move_pkg::addr_t exp,
                            input tile_move_pkg::addr_t act);
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_len(input string name, input tile_move_pkg::len_t exp,
                           input tile_move_pkg::len_t act);
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic report_fault(input string msg);
    errors++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  // background word, different for every address.
  function automatic tile_move_pkg::data_t fill_word(input tile_move_pkg::addr_t a);
    return {a[15:0] ^ 16'h5eed, ~a[15:0]} ^ a;
  endfunction

  initial begin
    forever #5 clk_i = ~clk_i;                      // 10 ns period.
  end

  tile_move_top i_tile_move_top (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .job_req_i      (job_req_i),
    .src_addr_i     (src_addr_i),
    .dst_addr_i     (dst_addr_i),
    .len_i          (len_i),
    .job_ack_o      (job_ack_o),
    .tcdm_req_o     (tcdm_req_o),
    .tcdm_gnt_i     (tcdm_gnt_i),
    .tcdm_add_o     (tcdm_add_o),
    .tcdm_wen_o     (tcdm_wen_o),
    .tcdm_be_o      (tcdm_be_o),
    .tcdm_data_o    (tcdm_data_o),
    .tcdm_r_valid_i (tcdm_r_valid_i),
    .tcdm_r_data_i  (tcdm_r_data_i)
  );

  // ########################################################################
  // memory model, one-cycle read response
  // ########################################################################
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      tcdm_gnt_i     <= 1'b0;
      tcdm_r_valid_i <= 1'b0;
    end else begin
      tcdm_gnt_i     <= tcdm_gnt_i ? 1'($urandom % 2) : 1'b1;  // never low twice.
      tcdm_r_valid_i <= 1'b0;
      if (tcdm_req_o && !in_job) report_fault("memory request seen outside a job");
      if (tcdm_req_o && tcdm_gnt_i && in_job) begin
        if (tcdm_wen_o) begin                       // granted read.
          if (wr_cnt != 0) report_fault("read granted after the first write");
          if (rd_cnt >= cur_len) report_fault("more reads than the job length");
          check_addr("read address", cur_src + rd_cnt, tcdm_add_o);
          tcdm_r_data_i  <= mem[tcdm_add_o[7:0]];
          tcdm_r_valid_i <= 1'b1;
          rd_cnt++;
        end else begin                              // granted write.
          if (rd_cnt != cur_len) report_fault("write granted before all reads");
          if (wr_cnt >= cur_len) report_fault("more writes than the job length");
          if (tcdm_be_o != '1) report_fault("write without all byte enables");
          check_addr("write address", cur_dst + wr_cnt, tcdm_add_o);
          check_word("write data", gold[cur_base + cur_len + wr_cnt], tcdm_data_o);
          mem[tcdm_add_o[7:0]] = tcdm_data_o;
          wr_cnt++;
        end
      end
    end
  end

  // ########################################################################
  // job driver, four-phase
  // ########################################################################
  task automatic run_job(input int unsigned ptr);
    tile_move_pkg::len_t len;
    len      = tile_move_pkg::len_t'(gold[ptr + 2]);
    cur_src  = gold[ptr];
    cur_dst  = gold[ptr + 1];
    cur_len  = len;
    cur_base = ptr + 3;
    rd_cnt   = 0;
    wr_cnt   = 0;
    for (int a = 0; a < MEM_WORDS; a++) mem[a] = fill_word(tile_move_pkg::addr_t'(a));
    for (int k = 0; k < len; k++) mem[8'(cur_src + k)] = gold[cur_base + k];
    in_job = 1'b1;
    @(posedge clk_i);
    job_req_i  <= 1'b1;
    src_addr_i <= cur_src;
    dst_addr_i <= cur_dst;
    len_i      <= len;
    do @(posedge clk_i); while (!job_ack_o);        // watchdog bounds this.
    check_len("granted writes at ack", len, tile_move_pkg::len_t'(wr_cnt));
    @(posedge clk_i);
    if (!job_ack_o) report_fault("ack dropped while the job request was still high");
    job_req_i <= 1'b0;
    @(posedge clk_i);                               // ack falls on this edge.
    @(posedge clk_i);
    if (job_ack_o) report_fault("ack still high one cycle after the job request fell");
    for (int k = 0; k < len; k++) begin
      check_word("destination word", gold[cur_base + len + k], mem[8'(cur_dst + k)]);
    end
    check_word("word below destination", fill_word(cur_dst - 1), mem[8'(cur_dst - 1)]);
    check_word("word above destination", fill_word(cur_dst + len), mem[8'(cur_dst + len)]);
    in_job = 1'b0;
  endtask

  initial begin
    int unsigned njobs;
    int unsigned ptr;
    void'($urandom(70));
    job_req_i  = 1'b0;
    src_addr_i = '0;
    dst_addr_i = '0;
    len_i      = '0;
    $readmemh("verif/tile_move_golden.txt", gold);
    njobs = gold[0];
    ptr   = 1;
    for (int j = 0; j < njobs; j++) begin           // 40 cycles per word.
      limit_cycles += 40 * gold[ptr + 2];
      ptr += 3 + 2 * gold[ptr + 2];
    end
    limit_cycles += 200;
    limit_ready = 1'b1;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (4) begin                                // quiet before the first job.
      @(posedge clk_i);
      if (tcdm_req_o || job_ack_o) report_fault("request or ack active before the first job");
    end
    ptr = 1;
    for (int j = 0; j < njobs; j++) begin           // back to back.
      run_job(ptr);
      ptr += 3 + 2 * gold[ptr + 2];
    end
    @(posedge clk_i);
    $display("tile mover run done: %0d jobs, %0d errors", njobs, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog, sized from the golden jobs.
  initial begin
    wait (limit_ready);
    repeat (limit_cycles) @(posedge clk_i);
    $display("timeout: jobs not finished within %0d cycles", limit_cycles);
    $display("Something failed");
    $finish;
  end

endmodule

/* verif/tile_move_asserts.sv */
// ##########################################################################
// tile mover protocol assertions.
// request stability, job ack release and write gating on the load channel.
// ##########################################################################

`timescale 1ns/1ps

module tile_move_asserts (
  input logic                            clk_i,
  input logic                            rst_n_i,
  input logic                            job_req_i,
  input logic                            job_ack_i,
  input logic                            req_i,       // memory port request.
  input logic                            gnt_i,
  input logic                            wen_i,
  input tile_move_pkg::addr_t            add_i,
  input tile_move_pkg::data_t            data_i,
  input logic                            store_req_i, // store channel request.
  input logic [tile_move_pkg::SEL_W-1:0] sel_i        // mux select.
);

  // a stalled request keeps its fields.
  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i && !gnt_i |=> req_i && $stable(add_i) && $stable(wen_i) && $stable(data_i))
    else $error("memory request changed before its grant");

  a_ack_release : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(job_ack_i) |-> !$past(job_req_i))
    else $error("job ack fell while the job request was high");

  // store side stays quiet while the load channel owns the port.
  a_no_load_write : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (sel_i == tile_move_pkg::CH_LOAD) |-> !store_req_i)
    else $error("write issued while the load channel was selected");

endmodule

bind tile_move_top tile_move_asserts i_asserts (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .job_req_i   (job_req_i),
  .job_ack_i   (job_ack_o),
  .req_i       (tcdm_req_o),
  .gnt_i       (tcdm_gnt_i),
  .wen_i       (tcdm_wen_o),
  .add_i       (tcdm_add_o),
  .data_i      (tcdm_data_o),
  .store_req_i (chan_req[tile_move_pkg::CH_STORE]),
  .sel_i       (sel)
);

/* verif/tile_move_golden.txt */
// first word: job count. per job: src dst len, then len source words,
// then len expected destination words (all hex).
4
10 80 1
a1b2c3d4
a1b2c3d4
20 90 8
00000001 11111112 22222223 33333334 44444445 55555556 66666667 77777778
00000001 11111112 22222223 33333334 44444445 55555556 66666667 77777778
38 a0 3
deadbeef cafef00d 0badc0de
deadbeef cafef00d 0badc0de
48 b8 5
13579bdf 2468ace0 fedcba98 01234567 89abcdef
13579bdf 2468ace0 fedcba98 01234567 89abcdef

/* verilog/hci_core_mux_static.sv */
// ##########################################################################
// static HCI multiplexer.
// puts one of NB_CHAN initiators on the memory port, picked by sel_i.
// only valid when the initiators are never active at the same time.
// ##########################################################################

`timescale 1ns/1ps

module hci_core_mux_static #(
  parameter int unsigned NB_CHAN = 2
) (
  input  logic [$clog2(NB_CHAN)-1:0]                  sel_i,
  // initiator side.
  input  logic [NB_CHAN-1:0]                          in_req_i,
  input  logic [NB_CHAN-1:0]                          in_wen_i,
  input  tile_move_pkg::addr_t [NB_CHAN-1:0]          in_add_i,
  input  tile_move_pkg::data_t [NB_CHAN-1:0]          in_data_i,
  input  logic [NB_CHAN-1:0][tile_move_pkg::BE_W-1:0] in_be_i,
  output logic [NB_CHAN-1:0]                          in_gnt_o,
  output logic [NB_CHAN-1:0]                          in_r_valid_o,
  output tile_move_pkg::data_t                        in_r_data_o,
  // memory side.
  output logic                                        out_req_o,
  output logic                                        out_wen_o,
  output tile_move_pkg::addr_t                        out_add_o,
  output tile_move_pkg::data_t                        out_data_o,
  output logic [tile_move_pkg::BE_W-1:0]              out_be_o,
  input  logic                                        out_gnt_i,
  input  logic                                        out_r_valid_i,
  input  tile_move_pkg::data_t                        out_r_data_i
);

  // handshake back only to the selected initiator.
  for (genvar ii = 0; ii < NB_CHAN; ii++) begin : gen_chan
    assign in_gnt_o[ii]     = (sel_i == ($clog2(NB_CHAN))'(ii)) ? out_gnt_i     : 1'b0;
    assign in_r_valid_o[ii] = (sel_i == ($clog2(NB_CHAN))'(ii)) ? out_r_valid_i : 1'b0;
  end

  assign in_r_data_o = out_r_data_i;            // broadcast, qualified by r_valid.

  assign out_req_o  = in_req_i[sel_i];
  assign out_wen_o  = in_wen_i[sel_i];
  assign out_add_o  = in_add_i[sel_i];
  assign out_data_o = in_data_i[sel_i];
  assign out_be_o   = in_be_i[sel_i];

endmodule

/* verilog/tile_access_channels.sv */
// ##########################################################################
// load and store issue paths.
// load side reads src..src+len-1 and fills the buffer from the responses.
// store side writes the buffer words back to dst..dst+len-1.
// ##########################################################################

`timescale 1ns/1ps

module tile_access_channels (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            load_en_i,
  input  logic                            store_en_i,
  input  tile_move_pkg::addr_t            src_addr_i,
  input  tile_move_pkg::addr_t            dst_addr_i,
  input  logic [tile_move_pkg::IDX_W-1:0] idx_i,       // granted count.
  input  tile_move_pkg::len_t             len_i,
  // load channel.
  input  logic                            load_gnt_i,
  input  logic                            r_valid_i,
  input  tile_move_pkg::data_t            r_data_i,
  output logic                            load_req_o,
  output tile_move_pkg::addr_t            load_add_o,
  output logic                            load_done_o,
  // buffer write port.
  output logic                            buf_we_o,
  output logic [tile_move_pkg::IDX_W-1:0] buf_widx_o,
  output tile_move_pkg::data_t            buf_wdata_o,
  // store channel.
  input  tile_move_pkg::data_t            buf_rdata_i,  // word at idx_i.
  output logic                            store_req_o,
  output tile_move_pkg::addr_t            store_add_o,
  output tile_move_pkg::data_t            store_data_o
);

  // ########################################################################
  // load side
  // ########################################################################

  logic                load_issue;
  tile_move_pkg::len_t rcnt_q;     // responses received.
  logic [1:0]          pend_q;     // reads granted, not yet answered.

  assign load_req_o = load_en_i;                               // one read per idx.
  assign load_add_o = src_addr_i + tile_move_pkg::addr_t'(idx_i);
  assign load_issue = load_req_o & load_gnt_i;

  // response index, rewound once the store phase runs.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i)        rcnt_q <= '0;
    else if (store_en_i) rcnt_q <= '0;
    else if (r_valid_i)  rcnt_q <= rcnt_q + 1'b1;
  end

  // in-flight reads, at most two with a one-cycle memory.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q <= '0;
    end else begin
      unique case ({load_issue, r_valid_i})
        2'b10:   pend_q <= pend_q + 1'b1;                       // new read out.
        2'b01:   pend_q <= pend_q - 1'b1;                       // read answered.
        default: pend_q <= pend_q;                              // none or both.
      endcase
    end
  end

  assign buf_we_o    = r_valid_i;                               // one write per response.
  assign buf_widx_o  = rcnt_q[tile_move_pkg::IDX_W-1:0];
  assign buf_wdata_o = r_data_i;

  assign load_done_o = (rcnt_q == len_i) && (pend_q == '0);     // buffer complete.

  // ########################################################################
  // store side
  // ########################################################################

  assign store_req_o  = store_en_i;
  assign store_add_o  = dst_addr_i + tile_move_pkg::addr_t'(idx_i);
  assign store_data_o = buf_rdata_i;                            // stable while idx holds.

endmodule

/* verilog/tile_buffer.sv */
// ##########################################################################
// tile buffer.
// BUF_DEPTH words, one synchronous write port and one combinational read.
// ##########################################################################

`timescale 1ns/1ps

module tile_buffer (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            we_i,
  input  logic [tile_move_pkg::IDX_W-1:0] widx_i,
  input  tile_move_pkg::data_t            wdata_i,
  input  logic [tile_move_pkg::IDX_W-1:0] ridx_i,
  output tile_move_pkg::data_t            rdata_o
);

  tile_move_pkg::data_t mem_q [tile_move_pkg::BUF_DEPTH];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < tile_move_pkg::BUF_DEPTH; i++) mem_q[i] <= '0;
    end else if (we_i) begin
      mem_q[widx_i] <= wdata_i;                 // visible next cycle.
    end
  end

  assign rdata_o = mem_q[ridx_i];               // no read latency.

endmodule

/* verilog/tile_move_ctrl.sv */
// ##########################################################################
// tile mover job controller.
// runs the four-phase job handshake and sequences load, drain and store.
// picks the memory channel and clears the issue counter between phases.
// ##########################################################################

`timescale 1ns/1ps

module tile_move_ctrl (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   job_req_i,
  input  tile_move_pkg::len_t                    len_i,
  input  logic                                   last_i,      // final grant of phase.
  input  logic                                   load_done_i, // all reads answered.
  output logic                                   job_ack_o,
  output logic [tile_move_pkg::SEL_W-1:0]        sel_o,
  output logic                                   cnt_clr_o,
  output logic                                   load_en_o,
  output logic                                   store_en_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,
    ST_DRAIN,
    ST_STORE,
    ST_ACK
  } state_e;

  state_e state_q, state_d;

  always_comb begin
    state_d   = state_q;
    cnt_clr_o = 1'b0;
    unique case (state_q)
      ST_IDLE: begin
        if (job_req_i) begin                       // req is low on entry, so level is the edge.
          cnt_clr_o = 1'b1;
          state_d   = (len_i == '0) ? ST_ACK : ST_LOAD; // empty job acks at once.
        end
      end
      ST_LOAD: begin
        if (last_i) state_d = ST_DRAIN;            // stop issuing reads.
      end
      ST_DRAIN: begin
        if (load_done_i) begin                     // buffer fully written.
          cnt_clr_o = 1'b1;
          state_d   = ST_STORE;
        end
      end
      ST_STORE: begin
        if (last_i) state_d = ST_ACK;              // last write granted.
      end
      ST_ACK: begin
        if (!job_req_i) state_d = ST_IDLE;         // ack drops next edge.
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) state_q <= ST_IDLE;
    else          state_q <= state_d;
  end

  assign job_ack_o  = (state_q == ST_ACK);
  assign load_en_o  = (state_q == ST_LOAD);
  assign store_en_o = (state_q == ST_STORE);
  // load stays selected while draining so r_valid reaches it.
  assign sel_o = (state_q == ST_STORE) ? tile_move_pkg::CH_STORE : tile_move_pkg::CH_LOAD;

endmodule

/* verilog/tile_move_pkg.sv */
// ##########################################################################
// tile mover shared definitions.
// widths, buffer depth and memory channel numbers used by the whole block.
// ##########################################################################

package tile_move_pkg;

  // ########################################################################
  // memory port widths
  // ########################################################################
  localparam int unsigned ADDR_W = 32;            // word address width.
  localparam int unsigned DATA_W = 32;            // data word width.
  localparam int unsigned BE_W   = DATA_W / 8;    // one enable per byte.

  // ########################################################################
  // job sizing
  // ########################################################################
  localparam int unsigned BUF_DEPTH = 8;          // max job length too.
  localparam int unsigned LEN_W     = 4;          // holds 0 to 8.
  localparam int unsigned IDX_W     = 3;          // buffer index.

  // ########################################################################
  // channels on the shared memory port
  // ########################################################################
  localparam int unsigned NB_CHAN = 2;
  localparam int unsigned SEL_W   = $clog2(NB_CHAN);

  localparam logic [SEL_W-1:0] CH_LOAD  = SEL_W'(0);  // read side.
  localparam logic [SEL_W-1:0] CH_STORE = SEL_W'(1);  // write side.

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [LEN_W-1:0]  len_t;

endpackage

/* verilog/tile_move_top.sv */
// ##########################################################################
// tile mover top level.
// copies 1 to 8 words from src to dst over one HCI memory port.
// load and store channels take turns on the port through a static mux.
// ##########################################################################

`timescale 1ns/1ps

module tile_move_top (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // job port, four-phase.
  input  logic                            job_req_i,
  input  tile_move_pkg::addr_t            src_addr_i,
  input  tile_move_pkg::addr_t            dst_addr_i,
  input  tile_move_pkg::len_t             len_i,
  output logic                            job_ack_o,
  // memory port.
  output logic                            tcdm_req_o,
  input  logic                            tcdm_gnt_i,
  output tile_move_pkg::addr_t            tcdm_add_o,
  output logic                            tcdm_wen_o,  // 1 read, 0 write.
  output logic [tile_move_pkg::BE_W-1:0]  tcdm_be_o,
  output tile_move_pkg::data_t            tcdm_data_o,
  input  logic                            tcdm_r_valid_i,
  input  tile_move_pkg::data_t            tcdm_r_data_i
);

  localparam int unsigned NB_CHAN = tile_move_pkg::NB_CHAN;

  logic [tile_move_pkg::SEL_W-1:0] sel;
  logic                            cnt_clr, cnt_step, cnt_last;
  logic                            load_en, store_en, load_done;
  logic [tile_move_pkg::IDX_W-1:0] idx;
  logic                            buf_we;
  logic [tile_move_pkg::IDX_W-1:0] buf_widx;
  tile_move_pkg::data_t            buf_wdata, buf_rdata;

  logic [NB_CHAN-1:0]                          chan_req, chan_wen, chan_gnt, chan_r_valid;
  tile_move_pkg::addr_t [NB_CHAN-1:0]          chan_add;
  tile_move_pkg::data_t [NB_CHAN-1:0]          chan_data;
  logic [NB_CHAN-1:0][tile_move_pkg::BE_W-1:0] chan_be;
  tile_move_pkg::data_t                        chan_r_data;

  assign chan_wen[tile_move_pkg::CH_LOAD]  = 1'b1;   // reads only.
  assign chan_wen[tile_move_pkg::CH_STORE] = 1'b0;   // writes only.
  assign chan_data[tile_move_pkg::CH_LOAD] = '0;
  assign chan_be[tile_move_pkg::CH_LOAD]   = '0;     // reads ignore byte enables.
  assign chan_be[tile_move_pkg::CH_STORE]  = '1;     // full-word writes.
  assign cnt_step = |(chan_req & chan_gnt);          // granted on the active channel.

  tile_move_ctrl i_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .job_req_i   (job_req_i),
    .len_i       (len_i),
    .last_i      (cnt_last),
    .load_done_i (load_done),
    .job_ack_o   (job_ack_o),
    .sel_o       (sel),
    .cnt_clr_o   (cnt_clr),
    .load_en_o   (load_en),
    .store_en_o  (store_en)
  );

  tile_word_counter i_counter (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clr_i   (cnt_clr),
    .step_i  (cnt_step),
    .len_i   (len_i),
    .idx_o   (idx),
    .last_o  (cnt_last)
  );

  tile_access_channels i_channels (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .load_en_i    (load_en),
    .store_en_i   (store_en),
    .src_addr_i   (src_addr_i),
    .dst_addr_i   (dst_addr_i),
    .idx_i        (idx),
    .len_i        (len_i),
    .load_gnt_i   (chan_gnt[tile_move_pkg::CH_LOAD]),
    .r_valid_i    (chan_r_valid[tile_move_pkg::CH_LOAD]),
    .r_data_i     (chan_r_data),
    .load_req_o   (chan_req[tile_move_pkg::CH_LOAD]),
    .load_add_o   (chan_add[tile_move_pkg::CH_LOAD]),
    .load_done_o  (load_done),
    .buf_we_o     (buf_we),
    .buf_widx_o   (buf_widx),
    .buf_wdata_o  (buf_wdata),
    .buf_rdata_i  (buf_rdata),
    .store_req_o  (chan_req[tile_move_pkg::CH_STORE]),
    .store_add_o  (chan_add[tile_move_pkg::CH_STORE]),
    .store_data_o (chan_data[tile_move_pkg::CH_STORE])
  );

  tile_buffer i_buffer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .we_i    (buf_we),
    .widx_i  (buf_widx),
    .wdata_i (buf_wdata),
    .ridx_i  (idx),
    .rdata_o (buf_rdata)
  );

  hci_core_mux_static #(
    .NB_CHAN (NB_CHAN)
  ) i_mux (
    .sel_i         (sel),
    .in_req_i      (chan_req),
    .in_wen_i      (chan_wen),
    .in_add_i      (chan_add),
    .in_data_i     (chan_data),
    .in_be_i       (chan_be),
    .in_gnt_o      (chan_gnt),
    .in_r_valid_o  (chan_r_valid),
    .in_r_data_o   (chan_r_data),
    .out_req_o     (tcdm_req_o),
    .out_wen_o     (tcdm_wen_o),
    .out_add_o     (tcdm_add_o),
    .out_data_o    (tcdm_data_o),
    .out_be_o      (tcdm_be_o),
    .out_gnt_i     (tcdm_gnt_i),
    .out_r_valid_i (tcdm_r_valid_i),
    .out_r_data_i  (tcdm_r_data_i)
  );

endmodule

/* verilog/tile_word_counter.sv */
// ##########################################################################
// issue counter.
// counts granted requests of the current phase, flags the final one.
// ##########################################################################

`timescale 1ns/1ps

module tile_word_counter (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            clr_i,   // new phase.
  input  logic                            step_i,  // request granted.
  input  tile_move_pkg::len_t             len_i,
  output logic [tile_move_pkg::IDX_W-1:0] idx_o,
  output logic                            last_o
);

  logic [tile_move_pkg::IDX_W-1:0] idx_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i)    idx_q <= '0;
    else if (clr_i)  idx_q <= '0;
    else if (step_i) idx_q <= idx_q + 1'b1;     // wraps after 8, phase ends first.
  end

  assign idx_o = idx_q;
  // same-cycle flag so the controller drops req on this grant.
  assign last_o = step_i &&
                  (tile_move_pkg::len_t'(idx_q) == len_i - tile_move_pkg::len_t'(1));

endmodule
